//--- rob_pkg.sv
package rob_pkg;

    // ROB geometry
    localparam int ROB_DEPTH = 16;
    localparam int PTR_W = 4;
    // index plus wrap (flip) bit
    localparam int IDX_W = PTR_W + 1;

    // dispatch and retire bandwidth
    localparam int ENQ_WIDTH = 2;
    localparam int COMMIT_WIDTH = 2;
    // common writeback ports from the execution units
    localparam int WB_PORTS = 2;

    // payload widths
    localparam int XLEN = 32;
    localparam int CAUSE_W = 5;
    // holds 0 to COMMIT_WIDTH
    localparam int CNT_W = 2;

    // age compare of two ROB indices
    // same lap: lower slot was allocated first
    // different lap: the index that has not wrapped yet sits higher and is older
    function automatic logic rob_is_older(input logic [IDX_W-1:0] a,
                                          input logic [IDX_W-1:0] b);
        if (a[PTR_W] == b[PTR_W]) begin
            return a[PTR_W-1:0] < b[PTR_W-1:0];
        end
        return a[PTR_W-1:0] > b[PTR_W-1:0];
    endfunction

endpackage

//--- rob_commit_if.sv
`timescale 1ns/1ns

interface rob_commit_if import rob_pkg::*; ();

    // commit window, slot 0 is the head
    // win_vld is a prefix mask of finished entries
    logic [COMMIT_WIDTH-1:0]       win_vld;
    logic [COMMIT_WIDTH*IDX_W-1:0] win_idx;
    logic [COMMIT_WIDTH*XLEN-1:0]  win_pc;
    logic [COMMIT_WIDTH-1:0]       win_is_br;

    // number of window slots retired at the next edge
    logic [CNT_W-1:0] commit_cnt;
    // empties the queue, both pointers back to zero
    logic flush;

    modport queue (
        output win_vld,
        output win_idx,
        output win_pc,
        output win_is_br,
        input  commit_cnt,
        input  flush
    );

    modport ctrl (
        input  win_vld,
        input  win_idx,
        input  win_pc,
        input  win_is_br,
        output commit_cnt,
        output flush
    );

endinterface

//--- rob_entry_queue.sv
`timescale 1ns/1ns

module rob_entry_queue import rob_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    // dispatch
    input  logic                      i_enq_vld,
    input  logic [ENQ_WIDTH-1:0]      i_enq_mask,
    input  logic [ENQ_WIDTH*XLEN-1:0] i_enq_pc,
    input  logic [ENQ_WIDTH-1:0]      i_enq_is_br,
    input  logic                      i_block_enq,
    output logic                      o_can_enq,
    output logic [ENQ_WIDTH*IDX_W-1:0] o_alloc_idx,
    // writeback
    input  logic [WB_PORTS-1:0]       i_wb_vld,
    input  logic [WB_PORTS*IDX_W-1:0] i_wb_idx,
    input  logic                      i_br_vld,
    input  logic [IDX_W-1:0]          i_br_idx,
    input  logic                      i_exc_vld,
    input  logic [IDX_W-1:0]          i_exc_idx,
    // commit side
    rob_commit_if.queue               cmt
);

    // per-entry storage
    logic [XLEN-1:0] pc_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] is_br_q;
    logic [ROB_DEPTH-1:0] fin_q;

    // pointers carry the flip bit
    logic [IDX_W-1:0] head_q;
    logic [IDX_W-1:0] tail_q;
    // occupied entries, 0 to ROB_DEPTH
    logic [IDX_W-1:0] used;

    logic [IDX_W-1:0] alloc_ptr [ENQ_WIDTH];
    logic [IDX_W-1:0] enq_cnt;
    logic             enq_fire;
    logic [IDX_W-1:0] win_ptr [COMMIT_WIDTH];

    assign used = tail_q - head_q;
    // room for a full dispatch group, and nothing pending in the controller
    assign o_can_enq = (used <= IDX_W'(ROB_DEPTH - ENQ_WIDTH)) && !i_block_enq;
    assign enq_fire = i_enq_vld && o_can_enq;

    // masked slots pack down behind the earlier valid ones
    // an idle slot just shows its natural position
    always_comb begin
        logic [IDX_W-1:0] seen;
        seen = '0;
        for (int i = 0; i < ENQ_WIDTH; i++) begin
            alloc_ptr[i] = tail_q + (i_enq_mask[i] ? seen : IDX_W'(i));
            o_alloc_idx[i*IDX_W +: IDX_W] = alloc_ptr[i];
            if (i_enq_mask[i]) begin
                seen = seen + 1'b1;
            end
        end
        enq_cnt = seen;
    end

    // entry payload, written on allocation only
    always_ff @(posedge clk) begin
        for (int i = 0; i < ENQ_WIDTH; i++) begin
            if (enq_fire && i_enq_mask[i]) begin
                pc_q[alloc_ptr[i][PTR_W-1:0]] <= i_enq_pc[i*XLEN +: XLEN];
                is_br_q[alloc_ptr[i][PTR_W-1:0]] <= i_enq_is_br[i];
            end
        end
    end

    // finished bits
    // allocation clears, any writeback port sets
    always_ff @(posedge clk) begin
        if (rst) begin
            fin_q <= '0;
        end else begin
            for (int i = 0; i < ENQ_WIDTH; i++) begin
                if (enq_fire && i_enq_mask[i]) begin
                    fin_q[alloc_ptr[i][PTR_W-1:0]] <= 1'b0;
                end
            end
            for (int p = 0; p < WB_PORTS; p++) begin
                if (i_wb_vld[p]) begin
                    fin_q[i_wb_idx[p*IDX_W +: PTR_W]] <= 1'b1;
                end
            end
            if (i_br_vld) begin
                fin_q[i_br_idx[PTR_W-1:0]] <= 1'b1;
            end
            if (i_exc_vld) begin
                fin_q[i_exc_idx[PTR_W-1:0]] <= 1'b1;
            end
        end
    end

    // pointers
    always_ff @(posedge clk) begin
        if (rst || cmt.flush) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            head_q <= head_q + IDX_W'(cmt.commit_cnt);
            if (enq_fire) begin
                tail_q <= tail_q + enq_cnt;
            end
        end
    end

    // commit window
    // stops at the first unfinished or empty slot
    always_comb begin
        logic run;
        run = 1'b1;
        for (int k = 0; k < COMMIT_WIDTH; k++) begin
            win_ptr[k] = head_q + IDX_W'(k);
            run = run && (IDX_W'(k) < used) && fin_q[win_ptr[k][PTR_W-1:0]];
            cmt.win_vld[k] = run;
            cmt.win_idx[k*IDX_W +: IDX_W] = win_ptr[k];
            cmt.win_pc[k*XLEN +: XLEN] = pc_q[win_ptr[k][PTR_W-1:0]];
            cmt.win_is_br[k] = is_br_q[win_ptr[k][PTR_W-1:0]];
        end
    end

endmodule

//--- rob_oldest_tracker.sv
`timescale 1ns/1ns

module rob_oldest_tracker import rob_pkg::*; #(
    parameter int PAYLOAD_W = 1
) (
    input  logic                 clk,
    input  logic                 rst,
    // event report
    input  logic                 i_wr_vld,
    input  logic [IDX_W-1:0]     i_wr_idx,
    input  logic [PAYLOAD_W-1:0] i_wr_payload,
    input  logic                 i_flush,
    // oldest event seen since the last flush
    output logic                 o_vld,
    output logic [IDX_W-1:0]     o_idx,
    output logic [PAYLOAD_W-1:0] o_payload
);

    logic                 vld_q;
    logic [IDX_W-1:0]     idx_q;
    logic [PAYLOAD_W-1:0] payload_q;
    logic                 take;

    // a late report of an older entry still replaces a younger one
    assign take = i_wr_vld && (!vld_q || rob_is_older(i_wr_idx, idx_q));

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            vld_q <= 1'b0;
        end else if (take) begin
            vld_q <= 1'b1;
        end
    end

    // index and payload follow the valid bit
    always_ff @(posedge clk) begin
        if (take) begin
            idx_q <= i_wr_idx;
            payload_q <= i_wr_payload;
        end
    end

    assign o_vld = vld_q;
    assign o_idx = idx_q;
    assign o_payload = payload_q;

endmodule

//--- rob_commit_ctrl.sv
`timescale 1ns/1ns

module rob_commit_ctrl import rob_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [XLEN-1:0]    i_tvec,
    // oldest mispredicted branch
    input  logic               i_mp_vld,
    input  logic [IDX_W-1:0]   i_mp_idx,
    input  logic [XLEN-1:0]    i_mp_target,
    // oldest exception
    input  logic               i_exc_vld,
    input  logic [IDX_W-1:0]   i_exc_idx,
    input  logic [CAUSE_W-1:0] i_exc_cause,
    // queue side
    rob_commit_if.ctrl         cmt,
    output logic               o_block_enq,
    // retire and squash
    output logic               o_commit_vld,
    output logic [CNT_W-1:0]   o_commit_cnt,
    output logic [IDX_W-1:0]   o_commit_idx,
    output logic               o_squash_vld,
    output logic [XLEN-1:0]    o_squash_pc,
    output logic               o_squash_is_trap,
    output logic [XLEN-1:0]    o_epc,
    output logic [CAUSE_W-1:0] o_cause
);

    // trap state, set for the one stall cycle before a trap squash
    logic               trap_q;
    logic               squash_q;
    logic               is_trap_q;
    logic [XLEN-1:0]    squash_pc_q;
    logic [XLEN-1:0]    epc_q;
    logic [CAUSE_W-1:0] cause_q;

    logic               exc_first;
    logic               mp_commit;
    logic               exc_at_head;
    logic [CNT_W-1:0]   cnt;

    // same entry on both trackers: the exception wins
    assign exc_first = i_exc_vld && !(i_mp_vld && rob_is_older(i_mp_idx, i_exc_idx));

    // walk the window in order
    // cut after the mispredicted branch, cut before the excepting entry
    always_comb begin
        logic             run;
        logic [IDX_W-1:0] slot_idx;
        cnt = '0;
        o_commit_idx = cmt.win_idx[IDX_W-1:0];
        mp_commit = 1'b0;
        exc_at_head = 1'b0;
        // nothing retires while a squash or a trap is in flight
        run = !(squash_q || trap_q);
        for (int k = 0; k < COMMIT_WIDTH; k++) begin
            slot_idx = cmt.win_idx[k*IDX_W +: IDX_W];
            if (run && cmt.win_vld[k]) begin
                if (exc_first && (slot_idx == i_exc_idx)) begin
                    run = 1'b0;
                    exc_at_head = (k == 0);
                end else begin
                    cnt = cnt + 1'b1;
                    o_commit_idx = slot_idx;
                    if (i_mp_vld && cmt.win_is_br[k] && (slot_idx == i_mp_idx)) begin
                        // the branch itself retires, the rest is wrong path
                        mp_commit = 1'b1;
                        run = 1'b0;
                    end
                end
            end else begin
                run = 1'b0;
            end
        end
    end

    // detect -> trap stall -> squash for exceptions
    // branch commit -> squash for mispredicts
    always_ff @(posedge clk) begin
        if (rst) begin
            trap_q <= 1'b0;
            squash_q <= 1'b0;
            is_trap_q <= 1'b0;
        end else begin
            trap_q <= exc_at_head;
            squash_q <= trap_q || mp_commit;
            if (trap_q || mp_commit) begin
                is_trap_q <= trap_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (trap_q) begin
            squash_pc_q <= i_tvec;
        end else if (mp_commit) begin
            squash_pc_q <= i_mp_target;
        end
        // head slot is the excepting entry
        if (exc_at_head) begin
            epc_q <= cmt.win_pc[XLEN-1:0];
            cause_q <= i_exc_cause;
        end
    end

    assign cmt.commit_cnt = cnt;
    assign cmt.flush = squash_q;
    assign o_block_enq = trap_q || squash_q;

    assign o_commit_vld = |cnt;
    assign o_commit_cnt = cnt;
    assign o_squash_vld = squash_q;
    assign o_squash_pc = squash_pc_q;
    assign o_squash_is_trap = is_trap_q;
    assign o_epc = epc_q;
    assign o_cause = cause_q;

endmodule

//--- rob_top.sv
`timescale 1ns/1ns

module rob_top import rob_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    // dispatch
    input  logic                       i_enq_vld,
    input  logic [ENQ_WIDTH-1:0]       i_enq_mask,
    input  logic [ENQ_WIDTH*XLEN-1:0]  i_enq_pc,
    input  logic [ENQ_WIDTH-1:0]       i_enq_is_br,
    output logic                       o_can_enq,
    output logic [ENQ_WIDTH*IDX_W-1:0] o_alloc_idx,
    // common writeback
    input  logic [WB_PORTS-1:0]        i_wb_vld,
    input  logic [WB_PORTS*IDX_W-1:0]  i_wb_idx,
    // branch writeback
    input  logic                       i_br_vld,
    input  logic [IDX_W-1:0]           i_br_idx,
    input  logic                       i_br_mispred,
    input  logic [XLEN-1:0]            i_br_target,
    // exception writeback
    input  logic                       i_exc_vld,
    input  logic [IDX_W-1:0]           i_exc_idx,
    input  logic [CAUSE_W-1:0]         i_exc_cause,
    input  logic [XLEN-1:0]            i_tvec,
    // retire
    output logic                       o_commit_vld,
    output logic [CNT_W-1:0]           o_commit_cnt,
    output logic [IDX_W-1:0]           o_commit_idx,
    // pipeline squash
    output logic                       o_squash_vld,
    output logic [XLEN-1:0]            o_squash_pc,
    output logic                       o_squash_is_trap,
    output logic [XLEN-1:0]            o_epc,
    output logic [CAUSE_W-1:0]         o_cause
);

    logic               block_enq;
    logic               mp_vld;
    logic [IDX_W-1:0]   mp_idx;
    logic [XLEN-1:0]    mp_target;
    logic               exc_vld;
    logic [IDX_W-1:0]   exc_idx;
    logic [CAUSE_W-1:0] exc_cause;

    rob_commit_if u_cmt_if ();

    rob_entry_queue u_queue (
        .clk         (clk),
        .rst         (rst),
        .i_enq_vld   (i_enq_vld),
        .i_enq_mask  (i_enq_mask),
        .i_enq_pc    (i_enq_pc),
        .i_enq_is_br (i_enq_is_br),
        .i_block_enq (block_enq),
        .o_can_enq   (o_can_enq),
        .o_alloc_idx (o_alloc_idx),
        .i_wb_vld    (i_wb_vld),
        .i_wb_idx    (i_wb_idx),
        .i_br_vld    (i_br_vld),
        .i_br_idx    (i_br_idx),
        .i_exc_vld   (i_exc_vld),
        .i_exc_idx   (i_exc_idx),
        .cmt         (u_cmt_if.queue)
    );

    // only mispredicting branches are tracked, target as payload
    rob_oldest_tracker #(.PAYLOAD_W(XLEN)) u_br_trk (
        .clk          (clk),
        .rst          (rst),
        .i_wr_vld     (i_br_vld && i_br_mispred),
        .i_wr_idx     (i_br_idx),
        .i_wr_payload (i_br_target),
        .i_flush      (u_cmt_if.flush),
        .o_vld        (mp_vld),
        .o_idx        (mp_idx),
        .o_payload    (mp_target)
    );

    rob_oldest_tracker #(.PAYLOAD_W(CAUSE_W)) u_exc_trk (
        .clk          (clk),
        .rst          (rst),
        .i_wr_vld     (i_exc_vld),
        .i_wr_idx     (i_exc_idx),
        .i_wr_payload (i_exc_cause),
        .i_flush      (u_cmt_if.flush),
        .o_vld        (exc_vld),
        .o_idx        (exc_idx),
        .o_payload    (exc_cause)
    );

    rob_commit_ctrl u_ctrl (
        .clk              (clk),
        .rst              (rst),
        .i_tvec           (i_tvec),
        .i_mp_vld         (mp_vld),
        .i_mp_idx         (mp_idx),
        .i_mp_target      (mp_target),
        .i_exc_vld        (exc_vld),
        .i_exc_idx        (exc_idx),
        .i_exc_cause      (exc_cause),
        .cmt              (u_cmt_if.ctrl),
        .o_block_enq      (block_enq),
        .o_commit_vld     (o_commit_vld),
        .o_commit_cnt     (o_commit_cnt),
        .o_commit_idx     (o_commit_idx),
        .o_squash_vld     (o_squash_vld),
        .o_squash_pc      (o_squash_pc),
        .o_squash_is_trap (o_squash_is_trap),
        .o_epc            (o_epc),
        .o_cause          (o_cause)
    );

endmodule

//--- rob_checker.sv
`timescale 1ns/1ns

module rob_checker import rob_pkg::*; (
    input logic             clk,
    input logic             rst,
    input logic             i_commit_vld,
    input logic [CNT_W-1:0] i_commit_cnt,
    input logic             i_squash_vld
);

    // assertion failures, read by the testbench at the end
    int err_cnt = 0;

    // retire bandwidth
    a_cnt_max: assert property (@(posedge clk) disable iff (rst)
        i_commit_cnt <= CNT_W'(COMMIT_WIDTH))
        else begin
            err_cnt = err_cnt + 1;
            $error("commit count above the commit width");
        end

    // squash is a single-cycle pulse
    a_squash_pulse: assert property (@(posedge clk) disable iff (rst)
        i_squash_vld |=> !i_squash_vld)
        else begin
            err_cnt = err_cnt + 1;
            $error("squash held for two cycles");
        end

    // nothing retires in the squash cycle
    a_no_commit_on_squash: assert property (@(posedge clk) disable iff (rst)
        i_squash_vld |-> !i_commit_vld)
        else begin
            err_cnt = err_cnt + 1;
            $error("commit during squash");
        end

endmodule

bind rob_top rob_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .i_commit_vld (o_commit_vld),
    .i_commit_cnt (o_commit_cnt),
    .i_squash_vld (o_squash_vld)
);

//--- rob_tb.sv
`timescale 1ns/1ns

module rob_tb import rob_pkg::*; ();

    logic                       clk;
    logic                       rst;
    logic                       i_enq_vld;
    logic [ENQ_WIDTH-1:0]       i_enq_mask;
    logic [ENQ_WIDTH*XLEN-1:0]  i_enq_pc;
    logic [ENQ_WIDTH-1:0]       i_enq_is_br;
    logic                       o_can_enq;
    logic [ENQ_WIDTH*IDX_W-1:0] o_alloc_idx;
    logic [WB_PORTS-1:0]        i_wb_vld;
    logic [WB_PORTS*IDX_W-1:0]  i_wb_idx;
    logic                       i_br_vld;
    logic [IDX_W-1:0]           i_br_idx;
    logic                       i_br_mispred;
    logic [XLEN-1:0]            i_br_target;
    logic                       i_exc_vld;
    logic [IDX_W-1:0]           i_exc_idx;
    logic [CAUSE_W-1:0]         i_exc_cause;
    logic [XLEN-1:0]            i_tvec;
    logic                       o_commit_vld;
    logic [CNT_W-1:0]           o_commit_cnt;
    logic [IDX_W-1:0]           o_commit_idx;
    logic                       o_squash_vld;
    logic [XLEN-1:0]            o_squash_pc;
    logic                       o_squash_is_trap;
    logic [XLEN-1:0]            o_epc;
    logic [CAUSE_W-1:0]         o_cause;

    // reference model: allocation pointer, entries still allowed to retire, per-slot state
    logic [31:0]          lfsr;
    logic [IDX_W-1:0]     tail;
    logic [IDX_W-1:0]     exp_q [$];
    logic [XLEN-1:0]      ent_pc [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] done;
    int                   n_chk;
    int                   n_err;
    int                   n_commit;
    int                   n_squash;
    // fields of the last squash seen
    logic                 sq_trap;
    logic [XLEN-1:0]      sq_pc;
    logic [XLEN-1:0]      sq_epc;
    logic [CAUSE_W-1:0]   sq_cause;

    initial clk = 1'b0;
    always #20 clk = ~clk;

    rob_top u_dut (.*);

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_chk++;
        if (got !== exp) begin
            n_err++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic timeout_abort(input string what);
        $display("timeout while waiting for %s", what);
        $display("checks %0d errors %0d", n_chk, n_err + 1);
        $display("TB FAILED");
        $finish;
    endtask

    // one-cycle strobes drop back to idle
    task automatic clear_inputs();
        i_enq_vld = 1'b0;
        i_enq_mask = '0;
        i_wb_vld = '0;
        i_br_vld = 1'b0;
        i_br_mispred = 1'b0;
        i_exc_vld = 1'b0;
    endtask

    // outputs have settled half a cycle after the edge
    task automatic observe();
        logic [IDX_W-1:0] idx;
        idx = '0;
        if (o_commit_vld) begin
            if (o_commit_cnt > COMMIT_WIDTH) begin
                n_err++;
                $display("FAIL o_commit_cnt %h above limit %h", o_commit_cnt, COMMIT_WIDTH);
            end
            for (int k = 0; k < o_commit_cnt; k++) begin
                if (exp_q.size() == 0) begin
                    n_err++;
                    $display("an entry committed that was expected to be squashed");
                end else begin
                    idx = exp_q.pop_front();
                    n_commit++;
                    if (!done[idx[PTR_W-1:0]]) begin
                        n_err++;
                        $display("entry %h committed before its writeback", idx);
                    end
                end
            end
            check_val("o_commit_idx", o_commit_idx, idx);
        end
        if (o_squash_vld) begin
            n_squash++;
            sq_trap = o_squash_is_trap;
            sq_pc = o_squash_pc;
            sq_epc = o_epc;
            sq_cause = o_cause;
            // flush takes effect at the coming edge
            tail = '0;
        end
    endtask

    task automatic cycle();
        @(negedge clk);
        observe();
        clear_inputs();
    endtask

    // allocate two entries, ok flags mark those expected to retire
    task automatic enqueue_pair(input logic [XLEN-1:0] pc0, input logic br0, input logic ok0,
                                input logic [XLEN-1:0] pc1, input logic br1, input logic ok1);
        int n;
        n = 0;
        cycle();
        while (!o_can_enq && n < 100) begin
            cycle();
            n++;
        end
        if (!o_can_enq) begin
            timeout_abort("o_can_enq");
        end else begin
            i_enq_vld = 1'b1;
            i_enq_mask = 2'b11;
            i_enq_pc = {pc1, pc0};
            i_enq_is_br = {br1, br0};
            ent_pc[tail[PTR_W-1:0]] = pc0;
            done[tail[PTR_W-1:0]] = 1'b0;
            if (ok0) exp_q.push_back(tail);
            tail = tail + 1'b1;
            ent_pc[tail[PTR_W-1:0]] = pc1;
            done[tail[PTR_W-1:0]] = 1'b0;
            if (ok1) exp_q.push_back(tail);
            tail = tail + 1'b1;
        end
    endtask

    task automatic wb_common(input logic [IDX_W-1:0] idx, input int port);
        cycle();
        i_wb_vld[port] = 1'b1;
        i_wb_idx[port*IDX_W +: IDX_W] = idx;
        done[idx[PTR_W-1:0]] = 1'b1;
    endtask

    task automatic wb_branch(input logic [IDX_W-1:0] idx, input logic mp, input logic [XLEN-1:0] tgt);
        cycle();
        i_br_vld = 1'b1;
        i_br_idx = idx;
        i_br_mispred = mp;
        i_br_target = tgt;
        done[idx[PTR_W-1:0]] = 1'b1;
    endtask

    task automatic wb_exc(input logic [IDX_W-1:0] idx, input logic [CAUSE_W-1:0] cause);
        cycle();
        i_exc_vld = 1'b1;
        i_exc_idx = idx;
        i_exc_cause = cause;
        done[idx[PTR_W-1:0]] = 1'b1;
    endtask

    task automatic wait_drain(input string what);
        int n;
        n = 0;
        cycle();
        while (exp_q.size() != 0 && n < 100) begin
            cycle();
            n++;
        end
        if (exp_q.size() != 0) timeout_abort(what);
    endtask

    task automatic wait_squash(input string what);
        int n;
        int s0;
        n = 0;
        s0 = n_squash;
        cycle();
        while (n_squash == s0 && n < 100) begin
            cycle();
            n++;
        end
        if (n_squash == s0) timeout_abort(what);
    endtask

    task automatic test_reset();
        cycle();
        check_val("o_can_enq", o_can_enq, 1);
        check_val("o_commit_vld", o_commit_vld, 0);
        check_val("o_squash_vld", o_squash_vld, 0);
        check_val("o_alloc_idx", o_alloc_idx, {IDX_W'(1), IDX_W'(0)});
    endtask

    task automatic test_in_order();
        logic [IDX_W-1:0] order [6];
        logic [IDX_W-1:0] base;
        logic [IDX_W-1:0] swap;
        logic [31:0]      r;
        int               c0;
        int               j;
        base = tail;
        c0 = n_commit;
        for (int i = 0; i < 3; i++) begin
            take_bits(32, r);
            enqueue_pair({r[31:2], 2'b00}, 1'b0, 1'b1, {r[31:2], 2'b00} + 4, 1'b0, 1'b1);
        end
        for (int i = 0; i < 6; i++) order[i] = base + IDX_W'(i);
        // shuffle the writeback order
        for (int i = 5; i > 0; i--) begin
            take_bits(8, r);
            j = r % (i + 1);
            swap = order[i];
            order[i] = order[j];
            order[j] = swap;
        end
        for (int i = 0; i < 6; i++) begin
            take_bits(1, r);
            wb_common(order[i], r[0]);
        end
        wait_drain("in-order commit");
        check_val("commit count", n_commit - c0, 6);
    endtask

    task automatic test_full();
        logic [IDX_W-1:0] base;
        logic [31:0]      r;
        int               n;
        base = tail;
        n = 0;
        take_bits(32, r);
        for (int i = 0; i < 8; i++) begin
            enqueue_pair(r + 8 * i, 1'b0, 1'b1, r + 8 * i + 4, 1'b0, 1'b1);
        end
        cycle();
        check_val("o_can_enq", o_can_enq, 0);
        wb_common(base, 0);
        wb_common(base + 1'b1, 1);
        cycle();
        while (!o_can_enq && n < 50) begin
            cycle();
            n++;
        end
        if (!o_can_enq) begin
            timeout_abort("o_can_enq after head commit");
        end else begin
            for (int i = 2; i < 16; i++) wb_common(base + IDX_W'(i), i % 2);
            wait_drain("full queue drain");
        end
    endtask

    // younger mispredict reported first, the older one must win
    task automatic test_mispredict();
        logic [IDX_W-1:0] base;
        logic [XLEN-1:0]  tgt_old;
        logic [XLEN-1:0]  tgt_young;
        logic [31:0]      r;
        int               s0;
        base = tail;
        s0 = n_squash;
        take_bits(32, r);
        tgt_old = {r[31:2], 2'b00};
        take_bits(32, r);
        tgt_young = {r[31:2], 2'b00};
        enqueue_pair(32'h1000, 1'b0, 1'b1, 32'h1004, 1'b1, 1'b1);
        enqueue_pair(32'h1008, 1'b1, 1'b0, 32'h100c, 1'b0, 1'b0);
        wb_branch(base + 2'd2, 1'b1, tgt_young);
        wb_common(base + 2'd3, 0);
        wb_branch(base + 2'd1, 1'b1, tgt_old);
        wb_common(base, 1);
        wait_squash("branch squash");
        repeat (4) cycle();
        check_val("squash count", n_squash - s0, 1);
        check_val("o_squash_pc", sq_pc, tgt_old);
        check_val("o_squash_is_trap", sq_trap, 0);
        check_val("pending commits", exp_q.size(), 0);
        check_val("o_alloc_idx", o_alloc_idx, {IDX_W'(1), IDX_W'(0)});
    endtask

    task automatic test_exception();
        logic [IDX_W-1:0]   base;
        logic [CAUSE_W-1:0] cause;
        logic [31:0]        r;
        int                 s0;
        base = tail;
        s0 = n_squash;
        take_bits(32, r);
        enqueue_pair({r[31:2], 2'b00}, 1'b0, 1'b1, {r[31:2], 2'b00} + 4, 1'b0, 1'b1);
        // third entry traps, fourth is wrong path
        enqueue_pair({r[31:2], 2'b00} + 8, 1'b0, 1'b0, {r[31:2], 2'b00} + 12, 1'b0, 1'b0);
        take_bits(CAUSE_W, r);
        cause = r[CAUSE_W-1:0];
        wb_common(base + 2'd3, 0);
        wb_exc(base + 2'd2, cause);
        wb_common(base, 1);
        wb_common(base + 1'b1, 0);
        wait_squash("trap squash");
        repeat (2) cycle();
        check_val("squash count", n_squash - s0, 1);
        check_val("o_squash_is_trap", sq_trap, 1);
        check_val("o_squash_pc", sq_pc, i_tvec);
        check_val("o_epc", sq_epc, ent_pc[2]);
        check_val("o_cause", sq_cause, cause);
        check_val("pending commits", exp_q.size(), 0);
    endtask

    // exception behind an older mispredict never traps
    task automatic test_priority();
        logic [IDX_W-1:0] base;
        logic [XLEN-1:0]  tgt;
        logic [31:0]      r;
        int               s0;
        base = tail;
        s0 = n_squash;
        take_bits(32, r);
        tgt = {r[31:2], 2'b00};
        enqueue_pair(32'h2000, 1'b1, 1'b1, 32'h2004, 1'b0, 1'b0);
        wb_exc(base + 1'b1, 5'h02);
        wb_branch(base, 1'b1, tgt);
        wait_squash("branch squash over exception");
        repeat (2) cycle();
        check_val("squash count", n_squash - s0, 1);
        check_val("o_squash_is_trap", sq_trap, 0);
        check_val("o_squash_pc", sq_pc, tgt);
        check_val("pending commits", exp_q.size(), 0);
    endtask

    initial begin
        lfsr = 32'h104a;
        tail = '0;
        done = '0;
        n_chk = 0;
        n_err = 0;
        n_commit = 0;
        n_squash = 0;
        rst = 1'b1;
        clear_inputs();
        i_enq_pc = '0;
        i_enq_is_br = '0;
        i_wb_idx = '0;
        i_br_idx = '0;
        i_br_target = '0;
        i_exc_idx = '0;
        i_exc_cause = '0;
        i_tvec = 32'h8000_0100;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        test_reset();
        test_in_order();
        test_full();
        test_mispredict();
        test_exception();
        test_priority();
        n_err = n_err + u_dut.u_checker.err_cnt;
        $display("checks %0d errors %0d assertion failures %0d",
                 n_chk, n_err, u_dut.u_checker.err_cnt);
        if (n_err == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
rob_pkg.sv
rob_commit_if.sv
rob_entry_queue.sv
rob_oldest_tracker.sv
rob_commit_ctrl.sv
rob_top.sv
rob_checker.sv
rob_tb.sv

//--- Bender.yml
package:
  name: rob

sources:
  - rob_pkg.sv
  - rob_commit_if.sv
  - rob_entry_queue.sv
  - rob_oldest_tracker.sv
  - rob_commit_ctrl.sv
  - rob_top.sv
  - target: test
    files:
      - rob_checker.sv
      - rob_tb.sv
